/* verilog/cpu_defs.svh */
// cpu width and field definitions
// shared by the packages, the RTL and the testbench
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// data and address width
`define CPU_WORD_W 16

// instruction fields
`define CPU_OP_W 4
`define CPU_IDX_W 6
`define CPU_OP_LSB 12
`define CPU_DST_LSB 6
`define CPU_SRC_LSB 0

// register file
`define CPU_NUM_REGS 4
`define CPU_P0_IDX 4

`endif

/* verilog/cpu_isa_pkg.sv */
// cpu instruction set types
// opcode encoding and register index field
`default_nettype none

`include "cpu_defs.svh"

package cpu_isa_pkg;

    // 4-bit opcodes, values not listed are skipped by control
    typedef enum logic [`CPU_OP_W-1:0] {
        OP_ADD   = 4'd0,
        OP_SUB   = 4'd1,
        OP_AND   = 4'd2,
        OP_OR    = 4'd3,
        OP_XOR   = 4'd4,
        OP_NOT   = 4'd5,
        OP_LOAD  = 4'd8,
        OP_STORE = 4'd9,
        OP_MOV   = 4'd10,
        OP_MOVI  = 4'd11
    } opcode_e;

    // dst and src fields share this width
    typedef logic [`CPU_IDX_W-1:0] reg_idx_t;

endpackage

`default_nettype wire

/* verilog/cpu_bus_pkg.sv */
// cpu datapath types
// word type and the internal bus source select
`default_nettype none

`include "cpu_defs.svh"

package cpu_bus_pkg;

    typedef logic [`CPU_WORD_W-1:0] word_t;

    // one driver on the internal bus at a time
    typedef enum logic [2:0] {
        BUS_NONE    = 3'd0,
        BUS_PC      = 3'd1,
        BUS_IMM     = 3'd2,
        BUS_MDR     = 3'd3,
        BUS_ALU     = 3'd4,
        BUS_REG_DST = 3'd5,
        BUS_REG_SRC = 3'd6
    } bus_src_e;

endpackage

`default_nettype wire

/* verilog/cpu_alu.sv */
// cpu ALU
// latches two operands off the bus and registers the result
`timescale 1ns/1ps
`default_nettype none

module cpu_alu (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   in1_ld,
    input  wire                   in2_ld,
    input  wire                   out_ld,
    input  wire cpu_isa_pkg::opcode_e op,
    input  wire cpu_bus_pkg::word_t   bus_in,
    output cpu_bus_pkg::word_t        result
);

    cpu_bus_pkg::word_t in1;
    cpu_bus_pkg::word_t in2;
    cpu_bus_pkg::word_t alu_val;

    // operand latches
    always_ff @(posedge clk) begin
        if (in1_ld) begin
            in1 <= bus_in;
        end
        if (in2_ld) begin
            in2 <= bus_in;
        end
    end

    always_comb begin
        case (op)
            cpu_isa_pkg::OP_ADD: alu_val = in1 + in2;
            cpu_isa_pkg::OP_SUB: alu_val = in1 - in2;
            cpu_isa_pkg::OP_AND: alu_val = in1 & in2;
            cpu_isa_pkg::OP_OR:  alu_val = in1 | in2;
            cpu_isa_pkg::OP_XOR: alu_val = in1 ^ in2;
            // NOT only looks at the src operand
            cpu_isa_pkg::OP_NOT: alu_val = ~in2;
            default:             alu_val = in1;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            result <= '0;
        end else if (out_ld) begin
            result <= alu_val;
        end
    end

endmodule

`default_nettype wire

/* verilog/cpu_regfile.sv */
// cpu register file
// R0-R3 plus output port P0 at index 4, higher indices read zero
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module cpu_regfile (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        write,
    input  wire cpu_isa_pkg::reg_idx_t wr_idx,
    input  wire cpu_isa_pkg::reg_idx_t rd_idx,
    input  wire cpu_bus_pkg::word_t    wr_data,
    output cpu_bus_pkg::word_t         rd_data,
    output cpu_bus_pkg::word_t         p0_out
);

    localparam int SEL_W = $clog2(`CPU_NUM_REGS);
    localparam cpu_isa_pkg::reg_idx_t NUM_IDX = `CPU_NUM_REGS;
    localparam cpu_isa_pkg::reg_idx_t P0_IDX  = `CPU_P0_IDX;

    cpu_bus_pkg::word_t regs [`CPU_NUM_REGS];
    logic wr_gp;
    logic wr_p0;

    // writes above P0 fall on the floor
    assign wr_gp = write && (wr_idx < NUM_IDX);
    assign wr_p0 = write && (wr_idx == P0_IDX);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            p0_out <= '0;
        end else begin
            if (wr_gp) begin
                regs[wr_idx[SEL_W-1:0]] <= wr_data;
            end
            if (wr_p0) begin
                p0_out <= wr_data;
            end
        end
    end

    always_comb begin
        if (rd_idx < NUM_IDX) begin
            rd_data = regs[rd_idx[SEL_W-1:0]];
        end else if (rd_idx == P0_IDX) begin
            rd_data = p0_out;
        end else begin
            rd_data = '0;
        end
    end

endmodule

`default_nettype wire

/* verilog/cpu_datapath.sv */
// cpu datapath
// PC, MAR, MDR and IR around one bus mux, with register file and ALU
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module cpu_datapath (
    input  wire                        clk,
    input  wire                        reset,
    input  wire cpu_bus_pkg::bus_src_e bus_src,
    input  wire                        pc_inc,
    input  wire                        mar_load,
    input  wire                        mdr_load_bus,
    input  wire                        mdr_load_mem,
    input  wire                        ir_load,
    input  wire                        alu_in1_ld,
    input  wire                        alu_in2_ld,
    input  wire                        alu_out_ld,
    input  wire                        reg_write,
    input  wire cpu_bus_pkg::word_t    mem_rdata,
    output cpu_isa_pkg::opcode_e       opcode,
    output cpu_bus_pkg::word_t         mem_addr,
    output cpu_bus_pkg::word_t         mem_wdata,
    output cpu_bus_pkg::word_t         p0_out
);

    cpu_bus_pkg::word_t data_bus;
    cpu_bus_pkg::word_t pc;
    cpu_bus_pkg::word_t mar;
    cpu_bus_pkg::word_t mdr;
    cpu_bus_pkg::word_t ir;
    cpu_bus_pkg::word_t imm;
    cpu_bus_pkg::word_t reg_rd_data;
    cpu_bus_pkg::word_t alu_result;
    cpu_isa_pkg::opcode_e  ir_op;
    cpu_isa_pkg::reg_idx_t ir_dst;
    cpu_isa_pkg::reg_idx_t ir_src;
    cpu_isa_pkg::reg_idx_t rd_idx;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc <= '0;
        end else if (pc_inc) begin
            pc <= pc + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mar_load) begin
            mar <= data_bus;
        end
        // memory side wins, both at once is flagged below
        if (mdr_load_mem) begin
            mdr <= mem_rdata;
        end else if (mdr_load_bus) begin
            mdr <= data_bus;
        end
        if (ir_load) begin
            ir <= data_bus;
        end
    end

    assign ir_op  = cpu_isa_pkg::opcode_e'(ir[`CPU_OP_LSB +: `CPU_OP_W]);
    assign ir_dst = ir[`CPU_DST_LSB +: `CPU_IDX_W];
    assign ir_src = ir[`CPU_SRC_LSB +: `CPU_IDX_W];
    assign imm    = cpu_bus_pkg::word_t'(ir_src);

    // bypass so control can branch in the cycle IR loads
    assign opcode = ir_load ? cpu_isa_pkg::opcode_e'(data_bus[`CPU_OP_LSB +: `CPU_OP_W])
                            : ir_op;

    assign rd_idx = (bus_src == cpu_bus_pkg::BUS_REG_SRC) ? ir_src : ir_dst;

    always_comb begin
        case (bus_src)
            cpu_bus_pkg::BUS_PC:      data_bus = pc;
            cpu_bus_pkg::BUS_IMM:     data_bus = imm;
            cpu_bus_pkg::BUS_MDR:     data_bus = mdr;
            cpu_bus_pkg::BUS_ALU:     data_bus = alu_result;
            cpu_bus_pkg::BUS_REG_DST: data_bus = reg_rd_data;
            cpu_bus_pkg::BUS_REG_SRC: data_bus = reg_rd_data;
            default:                  data_bus = '0;
        endcase
    end

    cpu_regfile regfile_i (
        .clk     (clk),
        .reset   (reset),
        .write   (reg_write),
        .wr_idx  (ir_dst),
        .rd_idx  (rd_idx),
        .wr_data (data_bus),
        .rd_data (reg_rd_data),
        .p0_out  (p0_out)
    );

    cpu_alu alu_i (
        .clk    (clk),
        .reset  (reset),
        .in1_ld (alu_in1_ld),
        .in2_ld (alu_in2_ld),
        .out_ld (alu_out_ld),
        .op     (ir_op),
        .bus_in (data_bus),
        .result (alu_result)
    );

    assign mem_addr  = mar;
    assign mem_wdata = mdr;

    mdr_one_source: assert property (
        @(posedge clk) disable iff (!reset) !(mdr_load_bus && mdr_load_mem)
    ) else $error("MDR loaded from bus and memory in the same cycle");

endmodule

`default_nettype wire

/* verilog/cpu_control.sv */
// cpu control unit
// one FSM for fetch and every execute sequence, drives all strobes
// and the memory request
`timescale 1ns/1ps
`default_nettype none

module cpu_control (
    input  wire                       clk,
    input  wire                       reset,
    input  wire cpu_isa_pkg::opcode_e opcode,
    input  wire                       mem_mfc,
    output cpu_bus_pkg::bus_src_e     bus_src,
    output logic                      pc_inc,
    output logic                      mar_load,
    output logic                      mdr_load_bus,
    output logic                      mdr_load_mem,
    output logic                      ir_load,
    output logic                      alu_in1_ld,
    output logic                      alu_in2_ld,
    output logic                      alu_out_ld,
    output logic                      reg_write,
    output logic                      mem_en,
    output logic                      mem_rw
);

    typedef enum logic [3:0] {
        S_IDLE, S_F1, S_F2, S_F3,
        S_E1, S_E2, S_E3, S_E4,
        S_MOV, S_MOVI,
        S_L1, S_L2, S_L3,
        S_S1, S_S2, S_S3
    } state_e;

    state_e state;
    state_e state_nxt;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: state_nxt = S_F1;
            S_F1:   state_nxt = S_F2;
            S_F2:   if (mem_mfc) state_nxt = S_F3;
            // opcode arrives through the IR bypass here
            S_F3: begin
                case (opcode)
                    cpu_isa_pkg::OP_ADD,
                    cpu_isa_pkg::OP_SUB,
                    cpu_isa_pkg::OP_AND,
                    cpu_isa_pkg::OP_OR,
                    cpu_isa_pkg::OP_XOR,
                    cpu_isa_pkg::OP_NOT:   state_nxt = S_E1;
                    cpu_isa_pkg::OP_MOV:   state_nxt = S_MOV;
                    cpu_isa_pkg::OP_MOVI:  state_nxt = S_MOVI;
                    cpu_isa_pkg::OP_LOAD:  state_nxt = S_L1;
                    cpu_isa_pkg::OP_STORE: state_nxt = S_S1;
                    default:               state_nxt = S_F1;
                endcase
            end
            S_E1:   state_nxt = S_E2;
            S_E2:   state_nxt = S_E3;
            S_E3:   state_nxt = S_E4;
            S_E4:   state_nxt = S_F1;
            S_MOV:  state_nxt = S_F1;
            S_MOVI: state_nxt = S_F1;
            S_L1:   state_nxt = S_L2;
            S_L2:   if (mem_mfc) state_nxt = S_L3;
            S_L3:   state_nxt = S_F1;
            S_S1:   state_nxt = S_S2;
            S_S2:   state_nxt = S_S3;
            S_S3:   if (mem_mfc) state_nxt = S_F1;
            default: state_nxt = S_F1;
        endcase
    end

    always_comb begin
        bus_src      = cpu_bus_pkg::BUS_NONE;
        pc_inc       = 1'b0;
        mar_load     = 1'b0;
        mdr_load_bus = 1'b0;
        mdr_load_mem = 1'b0;
        ir_load      = 1'b0;
        alu_in1_ld   = 1'b0;
        alu_in2_ld   = 1'b0;
        alu_out_ld   = 1'b0;
        reg_write    = 1'b0;
        mem_en       = 1'b0;
        // read unless a store is in progress
        mem_rw       = 1'b1;
        case (state)
            S_F1: begin
                bus_src  = cpu_bus_pkg::BUS_PC;
                mar_load = 1'b1;
                pc_inc   = 1'b1;
            end
            S_F2, S_L2: begin
                mem_en       = 1'b1;
                mdr_load_mem = mem_mfc;
            end
            S_F3: begin
                bus_src = cpu_bus_pkg::BUS_MDR;
                ir_load = 1'b1;
            end
            S_E1: begin
                bus_src    = cpu_bus_pkg::BUS_REG_DST;
                alu_in1_ld = 1'b1;
            end
            S_E2: begin
                bus_src    = cpu_bus_pkg::BUS_REG_SRC;
                alu_in2_ld = 1'b1;
            end
            S_E3: alu_out_ld = 1'b1;
            S_E4: begin
                bus_src   = cpu_bus_pkg::BUS_ALU;
                reg_write = 1'b1;
            end
            S_MOV: begin
                bus_src   = cpu_bus_pkg::BUS_REG_SRC;
                reg_write = 1'b1;
            end
            S_MOVI: begin
                bus_src   = cpu_bus_pkg::BUS_IMM;
                reg_write = 1'b1;
            end
            // src register holds the data address
            S_L1, S_S1: begin
                bus_src  = cpu_bus_pkg::BUS_REG_SRC;
                mar_load = 1'b1;
            end
            S_L3: begin
                bus_src   = cpu_bus_pkg::BUS_MDR;
                reg_write = 1'b1;
            end
            S_S2: begin
                bus_src      = cpu_bus_pkg::BUS_REG_DST;
                mdr_load_bus = 1'b1;
            end
            S_S3: begin
                mem_en = 1'b1;
                mem_rw = 1'b0;
            end
            default: ;
        endcase
    end

    // request held steady until the memory completes
    mem_req_held: assert property (
        @(posedge clk) disable iff (!reset)
        (mem_en && !mem_mfc) |=> (mem_en && $stable(mem_rw))
    ) else $error("memory request dropped or changed before mem_mfc");

    ir_vs_reg_write: assert property (
        @(posedge clk) disable iff (!reset) !(ir_load && reg_write)
    ) else $error("IR load and register write in the same cycle");

endmodule

`default_nettype wire

/* verilog/cpu_top.sv */
// cpu top level
// joins the control unit and datapath to the memory and port pins
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
    input  wire                     clk,
    input  wire                     reset,
    input  wire cpu_bus_pkg::word_t mem_rdata,
    input  wire                     mem_mfc,
    output cpu_bus_pkg::word_t      mem_addr,
    output cpu_bus_pkg::word_t      mem_wdata,
    output logic                    mem_en,
    output logic                    mem_rw,
    output cpu_bus_pkg::word_t      p0_out
);

    cpu_bus_pkg::bus_src_e bus_src;
    cpu_isa_pkg::opcode_e  opcode;
    logic pc_inc;
    logic mar_load;
    logic mdr_load_bus;
    logic mdr_load_mem;
    logic ir_load;
    logic alu_in1_ld;
    logic alu_in2_ld;
    logic alu_out_ld;
    logic reg_write;

    cpu_control control_i (
        .clk          (clk),
        .reset        (reset),
        .opcode       (opcode),
        .mem_mfc      (mem_mfc),
        .bus_src      (bus_src),
        .pc_inc       (pc_inc),
        .mar_load     (mar_load),
        .mdr_load_bus (mdr_load_bus),
        .mdr_load_mem (mdr_load_mem),
        .ir_load      (ir_load),
        .alu_in1_ld   (alu_in1_ld),
        .alu_in2_ld   (alu_in2_ld),
        .alu_out_ld   (alu_out_ld),
        .reg_write    (reg_write),
        .mem_en       (mem_en),
        .mem_rw       (mem_rw)
    );

    cpu_datapath datapath_i (
        .clk          (clk),
        .reset        (reset),
        .bus_src      (bus_src),
        .pc_inc       (pc_inc),
        .mar_load     (mar_load),
        .mdr_load_bus (mdr_load_bus),
        .mdr_load_mem (mdr_load_mem),
        .ir_load      (ir_load),
        .alu_in1_ld   (alu_in1_ld),
        .alu_in2_ld   (alu_in2_ld),
        .alu_out_ld   (alu_out_ld),
        .reg_write    (reg_write),
        .mem_rdata    (mem_rdata),
        .opcode       (opcode),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .p0_out       (p0_out)
    );

endmodule

`default_nettype wire

/* tests/tb_cpu_top.sv */
// cpu testbench
// memory model with a random mem_mfc delay, program and expected
// results come from the stimulus file
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module tb_cpu_top;

    localparam int MEM_WORDS = 256;
    localparam int REC_WORDS = 256;
    localparam int RUN_LIMIT = 20000;
    localparam int NUM_TESTS = 7;
    localparam int T_RESET = 1;
    localparam int T_FETCH = 2;

    // record kinds in the stimulus file
    localparam logic [15:0] REC_END      = 16'h0;
    localparam logic [15:0] REC_MEM      = 16'h1;
    localparam logic [15:0] REC_STORE    = 16'h2;
    localparam logic [15:0] REC_FINAL    = 16'h3;
    localparam logic [15:0] REC_END_ADDR = 16'h4;
    localparam logic [15:0] REC_CKPT     = 16'h5;

    logic clk;
    logic reset;
    logic [`CPU_WORD_W-1:0] mem_rdata;
    logic mem_mfc;
    logic [`CPU_WORD_W-1:0] mem_addr;
    logic [`CPU_WORD_W-1:0] mem_wdata;
    logic mem_en;
    logic mem_rw;
    logic [`CPU_WORD_W-1:0] p0_out;

    logic [`CPU_WORD_W-1:0] mem [MEM_WORDS];
    logic [15:0] recs [REC_WORDS];

    // expected stores in program order
    logic [`CPU_WORD_W-1:0] store_addr_q [$];
    logic [`CPU_WORD_W-1:0] store_data_q [$];
    int store_test_q [$];
    // p0_out values due when a fetch reads the given address
    logic [`CPU_WORD_W-1:0] ckpt_addr_q [$];
    logic [`CPU_WORD_W-1:0] ckpt_p0_q [$];
    int ckpt_test_q [$];

    logic [`CPU_WORD_W-1:0] final_p0;
    logic [`CPU_WORD_W-1:0] end_addr;
    logic [`CPU_WORD_W-1:0] fetch_pc;
    int final_test;
    int wait_left;
    logic busy;
    logic data_read_due;
    logic run_done;

    string test_name [NUM_TESTS] = '{"none", "reset_state", "fetch_order", "movi_mov_p0",
                                     "alu_ops", "load_store", "undefined_opcode"};
    int checks [NUM_TESTS];
    int errors [NUM_TESTS];
    int other_errors;

    cpu_top cpu_top_i (
        .clk       (clk),
        .reset     (reset),
        .mem_rdata (mem_rdata),
        .mem_mfc   (mem_mfc),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_en    (mem_en),
        .mem_rw    (mem_rw),
        .p0_out    (p0_out)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    task automatic compare_word(input int test, input logic [15:0] expected,
                                input logic [15:0] actual);
        checks[test]++;
        if (expected !== actual) begin
            errors[test]++;
            $display("ERR %s: expected %h, actual %h", test_name[test], expected, actual);
        end
    endtask

    task automatic report_test(input int test);
        $display("test %s: %0d checks, %0d errors", test_name[test], checks[test], errors[test]);
    endtask

    task automatic load_stimulus();
        int i;
        for (i = 0; i < MEM_WORDS; i++) begin
            // opcode 15 everywhere, low byte is the address
            mem[i] = {8'hF0, i[7:0]};
        end
        for (i = 0; i < REC_WORDS; i++) begin
            recs[i] = '0;
        end
        $readmemh("tests/cpu_stimulus.txt", recs);
        i = 0;
        while (i + 3 < REC_WORDS && recs[i] != REC_END) begin
            case (recs[i])
                REC_MEM: mem[recs[i+2][7:0]] = recs[i+3];
                REC_STORE: begin
                    store_test_q.push_back(int'(recs[i+1]));
                    store_addr_q.push_back(recs[i+2]);
                    store_data_q.push_back(recs[i+3]);
                end
                REC_FINAL: begin
                    final_test = int'(recs[i+1]);
                    final_p0 = recs[i+3];
                end
                REC_END_ADDR: end_addr = recs[i+2];
                REC_CKPT: begin
                    ckpt_test_q.push_back(int'(recs[i+1]));
                    ckpt_addr_q.push_back(recs[i+2]);
                    ckpt_p0_q.push_back(recs[i+3]);
                end
                default: begin
                    other_errors++;
                    $display("stimulus file has an unknown record kind %h", recs[i]);
                end
            endcase
            i += 4;
        end
    endtask

    task automatic check_store();
        if (store_addr_q.size() == 0) begin
            other_errors++;
            $display("unexpected store of %h to address %h", mem_wdata, mem_addr);
        end else begin
            compare_word(store_test_q[0], store_addr_q[0], mem_addr);
            compare_word(store_test_q[0], store_data_q[0], mem_wdata);
            void'(store_test_q.pop_front());
            void'(store_addr_q.pop_front());
            void'(store_data_q.pop_front());
        end
    endtask

    task automatic check_fetch(input logic [`CPU_WORD_W-1:0] word);
        compare_word(T_FETCH, fetch_pc, mem_addr);
        fetch_pc = fetch_pc + 16'd1;
        if (ckpt_addr_q.size() > 0) begin
            if (ckpt_addr_q[0] == mem_addr) begin
                compare_word(ckpt_test_q[0], ckpt_p0_q[0], p0_out);
                void'(ckpt_test_q.pop_front());
                void'(ckpt_addr_q.pop_front());
                void'(ckpt_p0_q.pop_front());
            end
        end
        if (mem_addr == end_addr) begin
            run_done = 1'b1;
        end else if (cpu_isa_pkg::opcode_e'(word[`CPU_OP_LSB +: `CPU_OP_W])
                     == cpu_isa_pkg::OP_LOAD) begin
            // next read belongs to the LOAD, not to fetch
            data_read_due = 1'b1;
        end
    endtask

    task automatic serve_access();
        logic [`CPU_WORD_W-1:0] word;
        word = mem[mem_addr[7:0]];
        if (!mem_rw) begin
            mem[mem_addr[7:0]] = mem_wdata;
            check_store();
        end else if (data_read_due) begin
            data_read_due = 1'b0;
            mem_rdata <= word;
        end else begin
            mem_rdata <= word;
            check_fetch(word);
        end
    endtask

    // memory model, completes each request after 1 to 4 cycles
    always @(posedge clk) begin
        if (!reset) begin
            mem_mfc <= 1'b0;
            busy = 1'b0;
        end else if (mem_mfc) begin
            mem_mfc <= 1'b0;
        end else if (mem_en) begin
            if (!busy) begin
                busy = 1'b1;
                wait_left = $urandom % 4;
            end
            if (wait_left == 0) begin
                busy = 1'b0;
                mem_mfc <= 1'b1;
                serve_access();
            end else begin
                wait_left--;
            end
        end
    end

    initial begin
        int cycles;
        int total_checks;
        int total_errors;
        void'($urandom(32'h7f5c_13eb));
        reset = 1'b0;
        mem_rdata = '0;
        mem_mfc = 1'b0;
        fetch_pc = '0;
        busy = 1'b0;
        wait_left = 0;
        data_read_due = 1'b0;
        run_done = 1'b0;
        other_errors = 0;
        final_test = T_RESET;
        final_p0 = '0;
        end_addr = '0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            checks[t] = 0;
            errors[t] = 0;
        end
        load_stimulus();

        // still ahead of the first rising edge
        #5;
        compare_word(T_RESET, 16'h0, {15'h0, mem_en});
        compare_word(T_RESET, 16'h0, p0_out);
        report_test(T_RESET);

        repeat (8) @(posedge clk);
        reset <= 1'b1;

        cycles = 0;
        while (!run_done && cycles < RUN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end

        if (!run_done) begin
            $display("timeout: end address %h was not fetched within %0d cycles",
                     end_addr, RUN_LIMIT);
            $display("Checks failed");
        end else begin
            compare_word(final_test, final_p0, p0_out);
            if (store_addr_q.size() != 0) begin
                other_errors++;
                $display("%0d expected stores never happened", store_addr_q.size());
            end
            if (ckpt_addr_q.size() != 0) begin
                other_errors++;
                $display("%0d p0_out checkpoints were never fetched", ckpt_addr_q.size());
            end
            total_checks = 0;
            total_errors = 0;
            for (int t = T_FETCH; t < NUM_TESTS; t++) begin
                report_test(t);
            end
            for (int t = 1; t < NUM_TESTS; t++) begin
                total_checks += checks[t];
                total_errors += errors[t];
            end
            $display("summary: %0d checks, %0d mismatches, %0d other failures",
                     total_checks, total_errors, other_errors);
            if (total_errors == 0 && other_errors == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+verilog
verilog/cpu_isa_pkg.sv
verilog/cpu_bus_pkg.sv
verilog/cpu_alu.sv
verilog/cpu_regfile.sv
verilog/cpu_datapath.sv
verilog/cpu_control.sv
verilog/cpu_top.sv
tests/tb_cpu_top.sv

/* run.sh */
#!/bin/sh
# build the cpu testbench with Verilator, run it and scan the log for failure
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_cpu_top -Mdir obj_dir -o tb_cpu_top > build.log 2>&1 &&
    ./obj_dir/tb_cpu_top > sim.log 2>&1 ||
    { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Checks failed" sim.log && exit 1 || exit 0

/* tests/cpu_stimulus.txt */
// columns: kind test address value, all hex
// kind 1 memory word, 2 expected store, 3 final p0_out, 4 end address, 5 p0_out at fetch
1 0 0000 B02A
1 0 0001 A100
1 0 0002 B06D
1 0 0003 B0BA
1 0 0004 0001
1 0 0005 9002
1 0 0006 1002
1 0 0007 9001
1 0 0008 2001
1 0 0009 9002
1 0 000A 3002
1 0 000B 9001
1 0 000C 4001
1 0 000D 9002
1 0 000E 50C1
1 0 000F 90C2
1 0 0010 B0FC
1 0 0011 8003
1 0 0012 9001
1 0 0013 B0BD
1 0 0014 8102
1 0 0015 6041
1 0 0016 C0C3
1 0 0017 9042
1 0 0018 90C1
1 0 003C BEEF
1 0 003D 7E81
5 3 0002 002A
5 5 0015 7E81
2 4 003A 0057
2 4 002D 001D
2 4 003A 000D
2 4 002D 003F
2 4 003A 0012
2 4 003A FFD2
2 5 002D BEEF
2 6 003D 002D
2 6 002D 003C
3 6 0000 7E81
4 0 0019 0000
